/* hw/tileGenPkg.sv */
package tileGenPkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int vramWindowBits = 13;             // Address bits inside one VRAM chip

   typedef logic [15:0]                cpuAddr_t;   // CPU address bus
   typedef logic [7:0]                 cpuData_t;   // CPU write data
   typedef logic [vramWindowBits-1:0]  vramAddr_t;  // RA to the VRAM chips
   typedef logic [8:0]                 beamCount_t; // H or V beam position
   typedef logic [2:0]                 chipSel_t;   // Active low, one per VRAM chip

   // ------------------------------
   // Bus cycle phases
   // ------------------------------
   // Two render phases then two CPU phases, one M24 cycle each
   typedef enum logic [1:0] {
      PhRender0 = 2'd0,   // Render slot, all clocks low
      PhRender1 = 2'd1,   // Render slot, PQ rises
      PhCpu0    = 2'd2,   // CPU slot, PE rises
      PhCpu1    = 2'd3    // CPU slot, write strobe and pixel step
   } phase_e;

   // ------------------------------
   // Structs
   // ------------------------------
   typedef struct packed {
      cpuAddr_t addr;     // AB as sampled
      logic     vramReq;  // VCS active
      logic     write;    // Write strobed this cycle
   } cpuAccess_s;

   typedef struct packed {
      logic [1:0] bankMap;  // 0x1C00 bits 1:0, VRAM chip map
      logic       nmiEn;    // 0x1D00 bit 0
      logic       firqEn;   // 0x1D00 bit 1
      logic       irqEn;    // 0x1D00 bit 2
      logic       flip;     // 0x1E80 bit 0
   } ctrlRegs_s;

   typedef struct packed {
      logic [5:0] tileCol;  // hCount[8:3], flipped
      logic [4:0] tileRow;  // vCount[7:3], flipped
   } beamPos_s;

   // ------------------------------
   // Register map
   // ------------------------------
   localparam cpuAddr_t regConfigAddr = 16'h1C00;  // VRAM config
   localparam cpuAddr_t regIrqEnAddr  = 16'h1D00;  // Interrupt enables
   localparam cpuAddr_t regFlipAddr   = 16'h1E80;  // Screen flip

endpackage

/* hw/clockPhaseGen.sv */
module clockPhaseGen import tileGenPkg::*; (
   input  logic   M24,
   input  logic   rstN,
   output phase_e phase,
   output logic   pixelEn,
   output logic   m12,
   output logic   pe,
   output logic   pq
);

   phase_e phaseNext;

   // Four-step ring replacing the divider flops
   always_comb begin
      case (phase)
         PhRender0: phaseNext = PhRender1;
         PhRender1: phaseNext = PhCpu0;
         PhCpu0:    phaseNext = PhCpu1;
         PhCpu1:    phaseNext = PhRender0;
         default:   phaseNext = PhRender0;
      endcase
   end

   always_ff @(posedge M24) begin
      if (!rstN) begin
         phase <= PhRender0;    // Bus clocks all low
      end else begin
         phase <= phaseNext;
      end
   end

   // 6809 quadrature clocks, PQ leads PE by a quarter cycle
   assign m12     = phase inside {PhRender1, PhCpu1};  // Half of M24
   assign pq      = phase inside {PhRender1, PhCpu0};
   assign pe      = phase inside {PhCpu0, PhCpu1};     // High in CPU slot
   assign pixelEn = (phase == PhCpu1);                 // One pixel per bus cycle

   // Quadrature edges never coincide
   assert property (@(posedge M24) disable iff (!rstN)
      !($changed(pe) && $changed(pq)))
      else $error("pe and pq changed on the same cycle");

endmodule

/* hw/cpuRegisterFile.sv */
module cpuRegisterFile import tileGenPkg::*; (
   input  logic       M24,
   input  logic       rstN,
   input  phase_e     phase,
   input  cpuAddr_t   ab,
   input  cpuData_t   db,
   input  logic       vcsN,
   input  logic       nrd,
   output cpuAccess_s access,
   output ctrlRegs_s  regs
);

   logic writeStb;
   logic hitConfig;
   logic hitIrqEn;
   logic hitFlip;

   // ------------------------------
   // Bus decode
   // ------------------------------
   // Write sampled at the end of the CPU slot, bus held stable by the CPU
   assign writeStb = (phase == PhCpu1) && !vcsN && nrd;

   always_comb begin
      access.addr    = ab;
      access.vramReq = !vcsN;     // VRAM window or register access
      access.write   = writeStb;
   end

   assign hitConfig = writeStb && (ab == regConfigAddr);
   assign hitIrqEn  = writeStb && (ab == regIrqEnAddr);
   assign hitFlip   = writeStb && (ab == regFlipAddr);

   // ------------------------------
   // Control registers
   // ------------------------------
   always_ff @(posedge M24) begin
      if (!rstN) begin
         regs <= '0;                     // All interrupts masked, no flip
      end else begin
         if (hitConfig) begin
            regs.bankMap <= db[1:0];     // Chip map select
         end
         if (hitIrqEn) begin
            regs.nmiEn  <= db[0];
            regs.firqEn <= db[1];
            regs.irqEn  <= db[2];        // Clearing a bit also acks its flag
         end
         if (hitFlip) begin
            regs.flip <= db[0];
         end
      end
   end

   // Strobe only at the end of the CPU slot, address held since the slot began
   assert property (@(posedge M24) disable iff (!rstN)
      access.write |-> (phase == PhCpu1) && $past(phase) == PhCpu0 && $stable(ab))
      else $error("Write strobe outside PhCpu1 or with a moving address");

endmodule

/* hw/videoCounters.sv */
module videoCounters import tileGenPkg::*; #(
   parameter beamCount_t hLineStart  = 9'd64,   // H reload
   parameter beamCount_t vFrameStart = 9'd248,  // V reload
   parameter beamCount_t vIrqLine    = 9'd496   // Vblank trigger line
) (
   input  logic      M24,
   input  logic      rstN,
   input  logic      pixelEn,
   input  ctrlRegs_s regs,
   output beamPos_s  beam,
   output logic      hvot,
   output logic      irqTrig,
   output logic      firqTrig,
   output logic      nmiTrig
);

   localparam beamCount_t beamLast = '1;  // 511, both counters wrap here

   beamCount_t hCount;
   beamCount_t vCount;
   beamCount_t vNext;
   logic       lineEnd;

   // ------------------------------
   // Beam counters
   // ------------------------------
   assign lineEnd = pixelEn && (hCount == beamLast);         // Last pixel of the line
   assign vNext   = (vCount == beamLast) ? vFrameStart
                                         : vCount + beamCount_t'(1);

   always_ff @(posedge M24) begin
      if (!rstN) begin
         hCount <= hLineStart;
         vCount <= vFrameStart;
      end else if (pixelEn) begin
         if (hCount == beamLast) begin
            hCount <= hLineStart;    // Reload instead of wrap to zero
            vCount <= vNext;
         end else begin
            hCount <= hCount + beamCount_t'(1);
         end
      end
   end

   // Tile position, flip inverts the tile bits
   always_comb begin
      beam.tileCol = hCount[8:3] ^ {6{regs.flip}};
      beam.tileRow = vCount[7:3] ^ {5{regs.flip}};
   end

   assign hvot = !(vCount == beamLast);   // Frame end, low on last line

   // ------------------------------
   // Interrupt triggers
   // ------------------------------
   // Pulses decode the line being entered
   assign irqTrig  = lineEnd && (vNext == vIrqLine);   // Vblank
   assign firqTrig = lineEnd && vNext[0];              // Every odd line
   assign nmiTrig  = lineEnd && (vNext[4:0] == 5'd0);  // Every 32 lines

   // H position stays inside the visible line range
   assert property (@(posedge M24) disable iff (!rstN)
      pixelEn |=> (hCount >= hLineStart))
      else $error("hCount left the range hLineStart to 511");

endmodule

/* hw/interruptCtrl.sv */
module interruptCtrl import tileGenPkg::*; #(
   parameter int unsigned resetFrames = 8   // Vblanks before CPU reset release
) (
   input  logic      M24,
   input  logic      rstN,
   input  ctrlRegs_s regs,
   input  logic      irqTrig,
   input  logic      firqTrig,
   input  logic      nmiTrig,
   output logic      irqN,
   output logic      firqN,
   output logic      nmiN,
   output logic      cpuRstN
);

   localparam int cntWidth = $clog2(resetFrames + 1);

   logic [2:0]          trig;      // IRQ, FIRQ, NMI order
   logic [2:0]          enable;
   logic [2:0]          flagN;
   logic [cntWidth-1:0] frameCnt;

   // ------------------------------
   // Interrupt flags
   // ------------------------------
   assign trig   = {irqTrig, firqTrig, nmiTrig};
   assign enable = {regs.irqEn, regs.firqEn, regs.nmiEn};

   // Set by trigger, acknowledged by clearing the enable
   always_ff @(posedge M24) begin
      if (!rstN) begin
         flagN <= '1;                   // No interrupt pending
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (!enable[i]) begin
               flagN[i] <= 1'b1;        // Ack or masked
            end else if (trig[i]) begin
               flagN[i] <= 1'b0;        // Assert line
            end
         end
      end
   end

   assign {irqN, firqN, nmiN} = flagN;

   // ------------------------------
   // Delayed CPU reset
   // ------------------------------
   // Counts vblanks whatever irqEn says
   always_ff @(posedge M24) begin
      if (!rstN) begin
         frameCnt <= '0;
         cpuRstN  <= 1'b0;             // Hold CPU in reset
      end else if (irqTrig && !cpuRstN) begin
         frameCnt <= frameCnt + 1'b1;
         if (frameCnt == cntWidth'(resetFrames - 1)) begin
            cpuRstN <= 1'b1;           // Release after last vblank
         end
      end
   end

   // Once released the CPU stays out of reset
   assert property (@(posedge M24) disable iff (!rstN)
      cpuRstN |=> cpuRstN)
      else $error("cpuRstN fell again after release");

endmodule

/* hw/vramAddrMux.sv */
module vramAddrMux import tileGenPkg::*; (
   input  phase_e     phase,
   input  cpuAccess_s access,
   input  ctrlRegs_s  regs,
   input  beamPos_s   beam,
   output vramAddr_t  ra,
   output chipSel_t   vramCsN,
   output chipSel_t   vramWeN
);

   logic     cpuSlot;
   logic [2:0] window;     // 8KB window of the CPU address
   logic [2:0] bankBase;
   chipSel_t chipHit;      // Active high chip decode

   assign cpuSlot  = phase inside {PhCpu0, PhCpu1};    // Same as PE high

   // ------------------------------
   // Chip bank decode
   // ------------------------------
   assign window   = access.addr[15:vramWindowBits];
   assign bankBase = {1'b0, regs.bankMap};

   // Three consecutive windows from the bank base map to chips 1, 2 and 0
   always_comb begin
      chipHit = '0;
      if (access.vramReq) begin
         if (window == bankBase) begin
            chipHit[1] = 1'b1;
         end else if (window == bankBase + 3'd1) begin
            chipHit[2] = 1'b1;
         end else if (window == bankBase + 3'd2) begin
            chipHit[0] = 1'b1;
         end
      end
   end

   // ------------------------------
   // Slot mux
   // ------------------------------
   // Render slot fetches the tile map entry for the beam
   assign ra = cpuSlot ? access.addr[vramWindowBits-1:0]
                       : {2'b00, beam.tileRow, beam.tileCol};

   assign vramCsN = cpuSlot ? ~chipHit : '0;           // Render reads all chips
   assign vramWeN = ~(chipHit & {3{access.write}});    // Never written in render slot

   // Checked as each write strobe ends on the values of the write cycle
   assert property (@(negedge access.write)
      $onehot0(~vramWeN))
      else $error("More than one VRAM chip written at once");

endmodule

/* hw/k052109Top.sv */
module k052109Top import tileGenPkg::*; #(
   parameter beamCount_t  hLineStart  = 9'd64,
   parameter beamCount_t  vFrameStart = 9'd248,
   parameter beamCount_t  vIrqLine    = 9'd496,
   parameter int unsigned resetFrames = 8
) (
   input  logic      M24,
   input  logic      rstN,
   // CPU bus
   input  cpuAddr_t  ab,
   input  cpuData_t  db,
   input  logic      vcsN,
   input  logic      nrd,
   // Bus clocks
   output logic      m12,
   output logic      pe,
   output logic      pq,
   // VRAM
   output vramAddr_t ra,
   output chipSel_t  vramCsN,
   output chipSel_t  vramWeN,
   // Video and CPU control
   output logic      hvot,
   output logic      irqN,
   output logic      firqN,
   output logic      nmiN,
   output logic      cpuRstN
);

   phase_e     phase;
   logic       pixelEn;
   cpuAccess_s access;
   ctrlRegs_s  regs;
   beamPos_s   beam;
   logic       irqTrig;
   logic       firqTrig;
   logic       nmiTrig;

   clockPhaseGen uClk (
      .M24, .rstN, .phase, .pixelEn, .m12, .pe, .pq
   );

   cpuRegisterFile uRegs (
      .M24, .rstN, .phase, .ab, .db, .vcsN, .nrd, .access, .regs
   );

   videoCounters #(
      .hLineStart  (hLineStart),
      .vFrameStart (vFrameStart),
      .vIrqLine    (vIrqLine)
   ) uCnt (
      .M24, .rstN, .pixelEn, .regs, .beam, .hvot, .irqTrig, .firqTrig, .nmiTrig
   );

   interruptCtrl #(
      .resetFrames (resetFrames)
   ) uIrq (
      .M24, .rstN, .regs, .irqTrig, .firqTrig, .nmiTrig, .irqN, .firqN, .nmiN, .cpuRstN
   );

   vramAddrMux uVram (
      .phase, .access, .regs, .beam, .ra, .vramCsN, .vramWeN
   );

endmodule

/* verification/tbK052109.sv */
module tbK052109 import tileGenPkg::*; ();

   // ------------------------------
   // DUT setup, 12-line frame
   // ------------------------------
   localparam beamCount_t lineStart    = 9'd480;      // 32 pixels per line
   localparam beamCount_t frameStart   = 9'd500;      // Lines 500 to 511
   localparam beamCount_t irqLine      = 9'd508;
   localparam int         vblanksToRun = 8;
   localparam int         frameCycles  = 12 * 32 * 4; // One pixel per bus cycle

   typedef enum {UntilPeHigh, UntilPeLow, UntilIrq, UntilFirq, UntilLastLine,
                 UntilCpuRun} waitTarget_e;

   logic      M24;
   logic      rstN;
   cpuAddr_t  ab;
   cpuData_t  db;
   logic      vcsN;
   logic      nrd;
   logic      m12;
   logic      pe;
   logic      pq;
   vramAddr_t ra;
   chipSel_t  vramCsN;
   chipSel_t  vramWeN;
   logic      hvot;
   logic      irqN;
   logic      firqN;
   logic      nmiN;
   logic      cpuRstN;

   // Reference state
   logic [1:0] refPhase;        // 0 render, 1 render, 2 CPU, 3 CPU
   beamCount_t refH;
   beamCount_t refV;
   beamCount_t refVNew;         // Line entered on wrap
   logic       refLineEnd;
   logic       refWrite;
   logic       refIrqHit;
   logic [1:0] refBank;
   logic       refNmiEn;
   logic       refFirqEn;
   logic       refIrqEn;
   logic       refFlip;
   logic       refIrqN;
   logic       refFirqN;
   logic       refNmiN;
   logic       refCpuRun;
   int         refVblanks;
   logic [2:0] window;
   logic [2:0] expHit;          // Active high chip select
   vramAddr_t  expRenderRa;

   k052109Top #(
      .hLineStart  (lineStart),
      .vFrameStart (frameStart),
      .vIrqLine    (irqLine),
      .resetFrames (vblanksToRun)
   ) UUT (
      .M24, .rstN, .ab, .db, .vcsN, .nrd, .m12, .pe, .pq, .ra, .vramCsN, .vramWeN,
      .hvot, .irqN, .firqN, .nmiN, .cpuRstN
   );

   initial begin
      M24 = 1'b0;
      forever #50 M24 = ~M24;     // Period 100
   end

   // ------------------------------
   // Reference model
   // ------------------------------
   always_comb begin
      refLineEnd  = (refPhase == 2'd3) && (refH == 9'd511);
      refVNew     = (refV == 9'd511) ? frameStart : refV + 9'd1;
      refWrite    = (refPhase == 2'd3) && !vcsN && nrd;     // Sampled at end of CPU slot
      refIrqHit   = refLineEnd && (refVNew == irqLine);
      expRenderRa = {2'b00, refV[7:3] ^ {5{refFlip}}, refH[8:3] ^ {6{refFlip}}};
      window      = ab[15:13];
      expHit      = 3'b000;
      if (!vcsN) begin
         if (window == {1'b0, refBank})
            expHit = 3'b010;                                // Base window is chip 1
         else if (window == {1'b0, refBank} + 3'd1)
            expHit = 3'b100;
         else if (window == {1'b0, refBank} + 3'd2)
            expHit = 3'b001;
      end
   end

   always @(posedge M24) begin
      if (!rstN) begin
         refPhase   <= 2'd0;
         refH       <= lineStart;
         refV       <= frameStart;
         {refBank, refNmiEn, refFirqEn, refIrqEn, refFlip} <= '0;
         {refIrqN, refFirqN, refNmiN} <= 3'b111;
         refCpuRun  <= 1'b0;
         refVblanks <= 0;
      end else begin
         refPhase <= refPhase + 2'd1;
         if (refPhase == 2'd3)
            refH <= (refH == 9'd511) ? lineStart : refH + 9'd1;
         if (refLineEnd)
            refV <= refVNew;
         if (refWrite && ab == regConfigAddr)
            refBank <= db[1:0];
         if (refWrite && ab == regIrqEnAddr)
            {refIrqEn, refFirqEn, refNmiEn} <= db[2:0];
         if (refWrite && ab == regFlipAddr)
            refFlip <= db[0];
         // Flag low after trigger, high once the enable is cleared
         refIrqN  <= !refIrqEn  ? 1'b1 : (refIrqHit ? 1'b0 : refIrqN);
         refFirqN <= !refFirqEn ? 1'b1 : ((refLineEnd && refVNew[0]) ? 1'b0 : refFirqN);
         refNmiN  <= !refNmiEn  ? 1'b1
                               : ((refLineEnd && refVNew[4:0] == 5'd0) ? 1'b0 : refNmiN);
         refVblanks <= refVblanks + int'(refIrqHit);       // Counts with irqEn clear too
         refCpuRun  <= (refVblanks + int'(refIrqHit)) >= vblanksToRun;
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------
   assert property (@(posedge M24) $rose(rstN) |->
      !m12 && !pe && !pq && irqN && firqN && nmiN && !cpuRstN && hvot)
      else abortRun($sformatf("FAILED at time %0t: outputs wrong after reset", $time));

   assert property (@(posedge M24) disable iff (!rstN)
      m12 == refPhase[0] && pe == refPhase[1] && pq == (refPhase inside {2'd1, 2'd2}))
      else abortRun($sformatf("FAILED at time %0t: bus clocks out of phase", $time));

   assert property (@(posedge M24) disable iff (!rstN) pe |-> ra == ab[12:0])
      else abortRun($sformatf("FAILED at time %0t: ra is not ab in the CPU slot", $time));

   assert property (@(posedge M24) disable iff (!rstN) !pe |-> ra == expRenderRa)
      else abortRun($sformatf("FAILED at time %0t: render ra %h, expected %h", $time,
                              $sampled(ra), $sampled(expRenderRa)));

   assert property (@(posedge M24) disable iff (!rstN)
      vramCsN == (pe ? ~expHit : 3'b000))
      else abortRun($sformatf("FAILED at time %0t: vramCsN %b with bank %0d", $time,
                              $sampled(vramCsN), $sampled(refBank)));

   assert property (@(posedge M24) disable iff (!rstN)
      vramWeN == (refWrite ? ~expHit : 3'b111))
      else abortRun($sformatf("FAILED at time %0t: vramWeN %b", $time, $sampled(vramWeN)));

   assert property (@(posedge M24) disable iff (!rstN)
      irqN == refIrqN && firqN == refFirqN && nmiN == refNmiN)
      else abortRun($sformatf("FAILED at time %0t: interrupt flags wrong", $time));

   assert property (@(posedge M24) disable iff (!rstN) hvot == (refV != 9'd511))
      else abortRun($sformatf("FAILED at time %0t: hvot wrong on line %0d", $time,
                              $sampled(refV)));

   assert property (@(posedge M24) disable iff (!rstN) cpuRstN == refCpuRun)
      else abortRun($sformatf("FAILED at time %0t: cpuRstN wrong", $time));

   // ------------------------------
   // Helpers
   // ------------------------------
   task automatic abortRun(input string line);
      $display("%s", line);
      $display("Finished with errors");
      $fatal(1);
   endtask

   function automatic logic targetReached(input waitTarget_e target);
      case (target)
         UntilPeHigh:   return pe;
         UntilPeLow:    return !pe;
         UntilIrq:      return !irqN;
         UntilFirq:     return !firqN;
         UntilLastLine: return !hvot;
         default:       return cpuRstN;
      endcase
   endfunction

   task automatic waitFor(input waitTarget_e target, input int limit);
      int n;
      n = 0;
      @(negedge M24);
      while (!targetReached(target)) begin
         if (n >= limit)
            abortRun($sformatf("Timed out waiting for %s", target.name()));
         n++;
         @(negedge M24);
      end
   endtask

   // One bus cycle from the falling edge of pe, held through all four phases
   task automatic cpuBusCycle(input cpuAddr_t addr, input cpuData_t data, input logic isWrite);
      waitFor(UntilPeHigh, 8);
      waitFor(UntilPeLow, 8);
      ab   = addr;
      db   = data;
      vcsN = 1'b0;
      nrd  = isWrite;
      repeat (4) @(negedge M24);
      vcsN = 1'b1;
      nrd  = 1'b0;
   endtask

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial begin
      rstN = 1'b0;
      ab   = '0;
      db   = '0;
      vcsN = 1'b1;
      nrd  = 1'b0;
      void'($urandom(32'h43f9_a3a4));
      repeat (16) @(negedge M24);
      rstN = 1'b1;

      // Random VRAM cycles under each bank map
      for (int bank = 0; bank < 4; bank++) begin
         cpuBusCycle(regConfigAddr, cpuData_t'(bank), 1'b1);
         repeat (12) cpuBusCycle(cpuAddr_t'($urandom()), cpuData_t'($urandom()),
                                 1'($urandom()));
      end

      // Flipped render addresses for two lines
      cpuBusCycle(regFlipAddr, 8'h01, 1'b1);
      repeat (256) @(negedge M24);
      cpuBusCycle(regFlipAddr, 8'h00, 1'b1);

      // All enables on, then acknowledge IRQ alone and the rest after
      cpuBusCycle(regIrqEnAddr, 8'h07, 1'b1);
      waitFor(UntilIrq, 2 * frameCycles);
      waitFor(UntilFirq, 2 * frameCycles);
      waitFor(UntilLastLine, 2 * frameCycles);
      cpuBusCycle(regIrqEnAddr, 8'h03, 1'b1);
      waitFor(UntilFirq, 2 * frameCycles);
      cpuBusCycle(regIrqEnAddr, 8'h00, 1'b1);

      // CPU reset release after the eighth vblank
      waitFor(UntilCpuRun, 12 * frameCycles);
      repeat (frameCycles) @(negedge M24);
      $display("Finished with no errors");
      $finish;
   end

endmodule

/* vlog.f */
hw/tileGenPkg.sv
hw/clockPhaseGen.sv
hw/cpuRegisterFile.sv
hw/videoCounters.sv
hw/interruptCtrl.sv
hw/vramAddrMux.sv
hw/k052109Top.sv
verification/tbK052109.sv

/* Bender.yml */
package:
  name: k052109

sources:
  - hw/tileGenPkg.sv
  - hw/clockPhaseGen.sv
  - hw/cpuRegisterFile.sv
  - hw/videoCounters.sv
  - hw/interruptCtrl.sv
  - hw/vramAddrMux.sv
  - hw/k052109Top.sv
  - target: test
    files:
      - verification/tbK052109.sv
